/* verilog/sb_rx_pkg.sv */
package sb_rx_pkg;

    // Bus geometry
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned WORD_WIDTH = 128;

    // Queue layout in host memory, as byte offsets from the queue base
    localparam int unsigned HEAD_OFFSET = 0;
    localparam int unsigned TAIL_OFFSET = 64;
    localparam int unsigned PACKET_OFFSET = 128;
    localparam int unsigned PACKET_SIZE = 16;

    // Packet payload carried in the upper half of a slot word
    localparam int unsigned DATA_WIDTH = 64;

    // One memory beat holds either an index word or a packet slot
    typedef union packed {
        struct packed {
            logic [WORD_WIDTH-33:0] unused;
            logic [31:0]            index;
        } idx;
        struct packed {
            logic [DATA_WIDTH-1:0] data;
            logic [30:0]           reserved;
            logic                  last;
            logic [31:0]           dest;
        } pkt;
    } mem_word_t;

endpackage

/* verilog/queue_fault.sv */
`timescale 1ns/100ps

module queue_fault (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [31:0]                         cfg_capacity,
    input  logic                                rd_done,
    input  logic                                rd_err,
    input  logic [sb_rx_pkg::ADDR_WIDTH-1:0]    rd_addr,
    input  logic                                wr_done,
    input  logic                                wr_err,
    input  logic [sb_rx_pkg::ADDR_WIDTH-1:0]    wr_addr,
    input  logic                                head_seen,
    input  logic [31:0]                         head_index,
    output logic                                fault,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    fault_addr
);

    logic rd_fault;
    logic wr_fault;
    logic head_fault;

    assign rd_fault = rd_done && rd_err;
    assign wr_fault = wr_done && wr_err;

    // A head index outside the ring means the producer side is corrupt
    assign head_fault = head_seen && (head_index >= cfg_capacity);

    always_ff @(posedge clk) begin
        if (reset) begin
            fault <= 1'b0;
        end else if (rd_fault || wr_fault || head_fault) begin
            fault <= 1'b1;
        end
    end

    // Only the first fault is kept
    always_ff @(posedge clk) begin
        if (!fault) begin
            if (rd_fault || head_fault) begin
                fault_addr <= rd_addr;
            end else if (wr_fault) begin
                fault_addr <= wr_addr;
            end
        end
    end

endmodule

/* verilog/mem_reader.sv */
`timescale 1ns/100ps

module mem_reader (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rd_req,
    input  logic [sb_rx_pkg::ADDR_WIDTH-1:0]    rd_addr,
    input  logic                                arready,
    input  logic [sb_rx_pkg::WORD_WIDTH-1:0]    rdata,
    input  logic [1:0]                          rresp,
    input  logic                                rvalid,
    output logic                                rd_done,
    output logic [sb_rx_pkg::WORD_WIDTH-1:0]    rd_data,
    output logic                                rd_err,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    araddr,
    output logic                                arvalid,
    output logic                                rready
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            arvalid <= 1'b0;
            rready <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rready <= 1'b1;
            rd_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rd_req) begin
                        arvalid <= 1'b1;
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid && rready) begin
                        rd_done <= 1'b1;
                        state <= ST_DONE;
                    end
                end
                default: begin
                    // The requester still holds rd_req during the done cycle
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && rd_req) begin
            araddr <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DATA && rvalid && rready) begin
            rd_data <= rdata;
            rd_err <= (rresp != 2'b00);
        end
    end

endmodule

/* verilog/mem_writer.sv */
`timescale 1ns/100ps

module mem_writer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_req,
    input  logic [sb_rx_pkg::ADDR_WIDTH-1:0]    wr_addr,
    input  logic [sb_rx_pkg::WORD_WIDTH-1:0]    wr_data,
    input  logic                                awready,
    input  logic                                wready,
    input  logic [1:0]                          bresp,
    input  logic                                bvalid,
    output logic                                wr_done,
    output logic                                wr_err,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    awaddr,
    output logic                                awvalid,
    output logic [sb_rx_pkg::WORD_WIDTH-1:0]    wdata,
    output logic                                wvalid,
    output logic                                bready
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_XFER = 2'd1;
    localparam logic [1:0] ST_RESP = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0] state;
    logic       aw_pending;
    logic       w_pending;

    // A channel is still pending when its valid is up and no handshake happens now
    assign aw_pending = awvalid && !awready;
    assign w_pending = wvalid && !wready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wr_req) begin
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (!aw_pending && !w_pending) begin
                        bready <= 1'b1;
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        wr_done <= 1'b1;
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && wr_req) begin
            awaddr <= wr_addr;
            wdata <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_RESP && bvalid) begin
            wr_err <= (bresp != 2'b00);
        end
    end

endmodule

/* verilog/sb_rx_queue.sv */
`timescale 1ns/100ps

module sb_rx_queue (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic                                ready,
    input  logic [sb_rx_pkg::ADDR_WIDTH-1:0]    cfg_base_addr,
    input  logic [31:0]                         cfg_capacity,
    input  logic                                rd_done,
    input  sb_rx_pkg::mem_word_t                rd_data,
    input  logic                                wr_done,
    input  logic                                fault,
    output logic [sb_rx_pkg::DATA_WIDTH-1:0]    data,
    output logic [31:0]                         dest,
    output logic                                last,
    output logic                                valid,
    output logic                                status_idle,
    output logic                                rd_req,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    rd_addr,
    output logic                                wr_req,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    wr_addr,
    output sb_rx_pkg::mem_word_t                wr_data,
    output logic                                head_seen,
    output logic [31:0]                         head_index
);

    import sb_rx_pkg::*;

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_RD_HEAD   = 3'd1;
    localparam logic [2:0] ST_RD_PACKET = 3'd2;
    localparam logic [2:0] ST_WR_TAIL   = 3'd3;
    localparam logic [2:0] ST_FAULT     = 3'd4;

    logic [2:0] state;
    logic [2:0] state_next;

    logic [31:0] head;
    logic [31:0] tail;
    logic [31:0] head_next;
    logic [31:0] tail_next;
    logic [31:0] tail_incr;
    logic        empty;
    logic        packet_done;

    logic [ADDR_WIDTH-1:0] head_addr;
    logic [ADDR_WIDTH-1:0] tail_addr;
    logic [ADDR_WIDTH-1:0] slot_addr;

    assign head_seen = (state == ST_RD_HEAD) && rd_done;
    assign head_index = rd_data.idx.index;
    assign packet_done = (state == ST_RD_PACKET) && rd_done;

    // The tail wraps back to slot 0 at the configured capacity
    assign tail_incr = (tail + 32'd1 == cfg_capacity) ? 32'd0 : tail + 32'd1;

    assign head_next = head_seen ? head_index : head;
    assign tail_next = packet_done ? tail_incr : tail;

    // Looking at the next values lets the FSM leave the head read in the same cycle
    assign empty = (head_next == tail_next);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (!valid && en) begin
                    if (empty) begin
                        state_next = ST_RD_HEAD;
                    end else begin
                        state_next = ST_RD_PACKET;
                    end
                end
            end
            ST_RD_HEAD: begin
                if (rd_done) begin
                    if (en && !empty) begin
                        state_next = ST_RD_PACKET;
                    end else begin
                        state_next = ST_IDLE;
                    end
                end
            end
            ST_RD_PACKET: begin
                // The tail is always written back once a packet has been read
                if (rd_done) begin
                    state_next = ST_WR_TAIL;
                end
            end
            ST_WR_TAIL: begin
                if (wr_done) begin
                    state_next = ST_IDLE;
                end
            end
            ST_FAULT: begin
                state_next = ST_FAULT;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (fault) begin
            state <= ST_FAULT;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= 32'd0;
            tail <= 32'd0;
        end else begin
            head <= head_next;
            tail <= tail_next;
        end
    end

    assign head_addr = cfg_base_addr + HEAD_OFFSET;
    assign tail_addr = cfg_base_addr + TAIL_OFFSET;
    assign slot_addr = cfg_base_addr + PACKET_OFFSET + tail * PACKET_SIZE;

    // Fault blocks requests in the cycle before the FSM reaches its fault state
    assign rd_req = !fault && ((state == ST_RD_HEAD) || (state == ST_RD_PACKET));
    assign rd_addr = (state == ST_RD_PACKET) ? slot_addr : head_addr;

    assign wr_req = !fault && (state == ST_WR_TAIL);
    assign wr_addr = tail_addr;

    always_comb begin
        wr_data = '0;
        wr_data.idx.index = tail;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (packet_done) begin
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    // A packet read only starts with valid low, so a held packet is never overwritten
    always_ff @(posedge clk) begin
        if (packet_done) begin
            data <= rd_data.pkt.data;
            dest <= rd_data.pkt.dest;
            last <= rd_data.pkt.last;
        end
    end

    assign status_idle = (state == ST_IDLE) && !fault;

endmodule

/* verilog/sb_rx_top.sv */
`timescale 1ns/100ps

module sb_rx_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic [sb_rx_pkg::ADDR_WIDTH-1:0]    cfg_base_addr,
    input  logic [31:0]                         cfg_capacity,
    output logic [sb_rx_pkg::DATA_WIDTH-1:0]    data,
    output logic [31:0]                         dest,
    output logic                                last,
    output logic                                valid,
    input  logic                                ready,
    output logic                                status_idle,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    araddr,
    output logic                                arvalid,
    input  logic                                arready,
    input  logic [sb_rx_pkg::WORD_WIDTH-1:0]    rdata,
    input  logic [1:0]                          rresp,
    input  logic                                rvalid,
    output logic                                rready,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    awaddr,
    output logic                                awvalid,
    input  logic                                awready,
    output logic [sb_rx_pkg::WORD_WIDTH-1:0]    wdata,
    output logic                                wvalid,
    input  logic                                axi_wready,
    input  logic [1:0]                          bresp,
    input  logic                                bvalid,
    output logic                                bready,
    output logic                                fault,
    output logic [sb_rx_pkg::ADDR_WIDTH-1:0]    fault_addr
);

    import sb_rx_pkg::*;

    logic                  rd_req;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  rd_done;
    logic [WORD_WIDTH-1:0] rd_data;
    logic                  rd_err;
    logic                  wr_req;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [WORD_WIDTH-1:0] wr_data;
    logic                  wr_done;
    logic                  wr_err;
    logic                  head_seen;
    logic [31:0]           head_index;

    sb_rx_queue queue_i (
        .clk(clk),
        .reset(reset),
        .en(en),
        .ready(ready),
        .cfg_base_addr(cfg_base_addr),
        .cfg_capacity(cfg_capacity),
        .rd_done(rd_done),
        .rd_data(rd_data),
        .wr_done(wr_done),
        .fault(fault),
        .data(data),
        .dest(dest),
        .last(last),
        .valid(valid),
        .status_idle(status_idle),
        .rd_req(rd_req),
        .rd_addr(rd_addr),
        .wr_req(wr_req),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .head_seen(head_seen),
        .head_index(head_index)
    );

    queue_fault fault_i (
        .clk(clk),
        .reset(reset),
        .cfg_capacity(cfg_capacity),
        .rd_done(rd_done),
        .rd_err(rd_err),
        .rd_addr(rd_addr),
        .wr_done(wr_done),
        .wr_err(wr_err),
        .wr_addr(wr_addr),
        .head_seen(head_seen),
        .head_index(head_index),
        .fault(fault),
        .fault_addr(fault_addr)
    );

    mem_reader reader_i (
        .clk(clk),
        .reset(reset),
        .rd_req(rd_req),
        .rd_addr(rd_addr),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rd_done(rd_done),
        .rd_data(rd_data),
        .rd_err(rd_err),
        .araddr(araddr),
        .arvalid(arvalid),
        .rready(rready)
    );

    mem_writer writer_i (
        .clk(clk),
        .reset(reset),
        .wr_req(wr_req),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .awready(awready),
        .wready(axi_wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .wr_done(wr_done),
        .wr_err(wr_err),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .wdata(wdata),
        .wvalid(wvalid),
        .bready(bready)
    );

endmodule

/* sim/sb_rx_properties.sv */
`timescale 1ns/100ps

module sb_rx_properties (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rd_packet_state,
    input  logic                                fault_state,
    input  logic                                fault,
    input  logic                                valid,
    input  logic                                ready,
    input  logic [sb_rx_pkg::DATA_WIDTH-1:0]    data,
    input  logic [31:0]                         dest,
    input  logic                                last,
    input  logic                                wr_req
);

    // A packet read only starts once the output register is empty
    no_valid_in_packet_read: assert property (
        @(posedge clk) disable iff (reset)
        rd_packet_state |-> !valid
    ) else $error("valid high while a packet slot is being read");

    output_held_under_backpressure: assert property (
        @(posedge clk) disable iff (reset)
        (valid && !ready) |=> (valid && $stable(data) && $stable(dest) && $stable(last))
    ) else $error("output packet changed while the sink held ready low");

    // The monitor's fault arrives before the FSM state follows it
    no_write_after_fault: assert property (
        @(posedge clk) disable iff (reset)
        fault |-> (!wr_req ##1 (fault_state && !wr_req))
    ) else $error("tail write requested after the fault was raised");

endmodule

/* sim/sb_rx_tb.sv */
`timescale 1ns/100ps

module sb_rx_tb;

    import sb_rx_pkg::*;

    localparam logic [31:0] BASE = 32'h0000_4000;
    localparam logic [31:0] CAPACITY = 32'd8;
    localparam int PACKET_COUNT = 200;
    localparam int PAUSE_COUNT = 120;
    localparam int TIMEOUT_CYCLES = PACKET_COUNT * 60 + 500;
    localparam int MEM_WORDS = 32;
    localparam int HEAD_IDX = HEAD_OFFSET / 16;
    localparam int TAIL_IDX = TAIL_OFFSET / 16;
    localparam int SLOT_IDX = PACKET_OFFSET / 16;

    logic                  clk;
    logic                  reset;
    logic                  en;
    logic [ADDR_WIDTH-1:0] cfg_base_addr;
    logic [31:0]           cfg_capacity;
    logic [DATA_WIDTH-1:0] data;
    logic [31:0]           dest;
    logic                  last;
    logic                  valid;
    logic                  ready;
    logic                  status_idle;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [WORD_WIDTH-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [WORD_WIDTH-1:0] wdata;
    logic                  wvalid;
    logic                  axi_wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic                  fault;
    logic [ADDR_WIDTH-1:0] fault_addr;

    // Host memory holding the head word, the tail word and the slots
    mem_word_t mem [0:MEM_WORDS-1];
    mem_word_t model_q [$];

    logic [31:0] rand_state = 32'd824;
    int          error_count [3];
    int          cycles = 0;
    int          accepted = 0;
    int          produced = 0;
    int          produce_limit = 0;
    int          slot_reads = 0;
    int          tail_writes = 0;
    logic [31:0] prod_head = 32'd0;
    logic        quiet_check = 1'b0;
    logic        fault_expected = 1'b0;

    logic                  r_busy;
    logic [ADDR_WIDTH-1:0] r_addr;
    mem_word_t             r_word;
    int                    r_delay;
    logic                  rvalid_next;
    logic                  aw_got;
    logic                  w_got;
    logic                  b_busy;
    logic [ADDR_WIDTH-1:0] aw_addr;
    mem_word_t             w_word;
    int                    b_delay;
    logic                  bvalid_next;
    logic                  held;
    logic [DATA_WIDTH-1:0] held_data;
    logic [31:0]           held_dest;
    logic                  held_last;

    sb_rx_top dut_i (
        .clk(clk),
        .reset(reset),
        .en(en),
        .cfg_base_addr(cfg_base_addr),
        .cfg_capacity(cfg_capacity),
        .data(data),
        .dest(dest),
        .last(last),
        .valid(valid),
        .ready(ready),
        .status_idle(status_idle),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .axi_wready(axi_wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .fault(fault),
        .fault_addr(fault_addr)
    );

    bind sb_rx_queue sb_rx_properties props_i (
        .clk(clk),
        .reset(reset),
        .rd_packet_state(state == ST_RD_PACKET),
        .fault_state(state == ST_FAULT),
        .fault(fault),
        .valid(valid),
        .ready(ready),
        .data(data),
        .dest(dest),
        .last(last),
        .wr_req(wr_req)
    );

    function automatic logic [15:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[31:16];
    endfunction

    function automatic logic in_range(input logic [31:0] addr);
        return (addr >= BASE) && (addr < BASE + MEM_WORDS * 16) && (addr[3:0] == 4'd0);
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return (addr - BASE) >> 4;
    endfunction

    task automatic check_hex(input string name, input logic [127:0] expected,
                             input logic [127:0] actual, input int kind);
        assert (expected === actual) else begin
            $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            error_count[kind]++;
        end
    endtask

    task automatic check_true(input logic cond, input string what, input int kind);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            error_count[kind]++;
        end
    endtask

    task automatic fill_memory();
        logic [31:0] pattern;
        for (int i = 0; i < MEM_WORDS; i++) begin
            pattern = (BASE + i * 16) ^ 32'h5a5a_0000;
            mem[i] = {4{pattern}};
        end
        mem[HEAD_IDX] = '0;
        mem[TAIL_IDX] = '0;
    endtask

    task automatic serve_read();
        logic [31:0] slot;
        if (rvalid && rready) begin
            r_busy = 1'b0;
            if (r_addr != BASE + HEAD_OFFSET) begin
                slot = BASE + PACKET_OFFSET + (slot_reads % CAPACITY) * PACKET_SIZE;
                check_hex("araddr", slot, r_addr, 2);
                slot_reads++;
            end
        end
        if (arvalid && arready) begin
            check_true(in_range(araddr), "read address outside the queue memory", 2);
            r_busy = 1'b1;
            r_addr = araddr;
            r_word = mem[word_index(araddr)];
            r_delay = next_random() % 4;
        end
        // The data beat comes after a random number of idle cycles
        if (r_busy && !rvalid) begin
            if (r_delay == 0) begin
                rvalid_next = 1'b1;
            end else begin
                r_delay--;
            end
        end else begin
            rvalid_next = r_busy;
        end
    endtask

    task automatic serve_write();
        if (bvalid && bready) begin
            b_busy = 1'b0;
        end
        if (awvalid && awready) begin
            aw_got = 1'b1;
            aw_addr = awaddr;
        end
        if (wvalid && axi_wready) begin
            w_got = 1'b1;
            w_word = wdata;
        end
        if (aw_got && w_got) begin
            check_hex("awaddr", BASE + TAIL_OFFSET, aw_addr, 1);
            if (in_range(aw_addr)) begin
                mem[word_index(aw_addr)] = w_word;
            end
            check_hex("tail word", slot_reads % CAPACITY, mem[TAIL_IDX].idx.index, 1);
            tail_writes++;
            aw_got = 1'b0;
            w_got = 1'b0;
            b_busy = 1'b1;
            b_delay = next_random() % 4;
        end
        if (b_busy && !bvalid) begin
            if (b_delay == 0) begin
                bvalid_next = 1'b1;
            end else begin
                b_delay--;
            end
        end else begin
            bvalid_next = b_busy;
        end
    endtask

    task automatic watch_output();
        mem_word_t expected;
        if (held) begin
            check_true(valid, "valid dropped before the sink took the packet", 0);
            check_hex("data", held_data, data, 0);
            check_hex("dest", held_dest, dest, 0);
            check_hex("last", held_last, last, 0);
        end
        held = valid && !ready;
        held_data = data;
        held_dest = dest;
        held_last = last;
        if (valid && ready) begin
            if (model_q.size() == 0) begin
                check_true(1'b0, "packet delivered that was never produced", 0);
            end else begin
                expected = model_q.pop_front();
                check_hex("dest", expected.pkt.dest, dest, 0);
                check_hex("last", expected.pkt.last, last, 0);
                check_hex("data", expected.pkt.data, data, 0);
            end
            accepted++;
        end
    endtask

    // The producer keeps one slot free, so a full ring never looks empty
    task automatic produce_packet();
        mem_word_t word;
        logic [15:0] coin;
        if (produced < produce_limit) begin
            coin = next_random();
            if (coin[0] && ((prod_head + 1) % CAPACITY != mem[TAIL_IDX].idx.index)) begin
                word = '0;
                word.pkt.data = {next_random(), next_random(), next_random(), next_random()};
                word.pkt.dest = {next_random(), next_random()};
                word.pkt.last = coin[5];
                mem[SLOT_IDX + prod_head] = word;
                model_q.push_back(word);
                prod_head = (prod_head + 1) % CAPACITY;
                word = '0;
                word.idx.index = prod_head;
                mem[HEAD_IDX] = word;
                produced++;
            end
        end
    endtask

    task automatic watch_status();
        if (quiet_check) begin
            check_hex("status_idle", 1, status_idle, 2);
            check_true(!arvalid, "read address issued while the receiver is disabled", 2);
        end
        if (fault) begin
            check_true(!arvalid && !awvalid, "bus request issued after the fault", 2);
            check_hex("status_idle", 0, status_idle, 2);
        end
        if (!fault_expected) begin
            check_true(!fault, "fault raised without a bad response or head index", 2);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory responder, sink and producer, one step per clock cycle
    initial begin
        arready = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        rvalid = 1'b0;
        awready = 1'b0;
        axi_wready = 1'b0;
        bresp = 2'b00;
        bvalid = 1'b0;
        ready = 1'b0;
        r_busy = 1'b0;
        r_word = '0;
        rvalid_next = 1'b0;
        aw_got = 1'b0;
        w_got = 1'b0;
        b_busy = 1'b0;
        bvalid_next = 1'b0;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                serve_read();
                serve_write();
                watch_output();
                produce_packet();
                watch_status();
            end
            @(posedge clk);
            #10;
            arready = (next_random() % 3) != 0;
            awready = (next_random() % 3) != 0;
            axi_wready = (next_random() % 3) != 0;
            ready = (next_random() % 4) != 0;
            rvalid = rvalid_next;
            rdata = r_word;
            bvalid = bvalid_next;
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        mem_word_t corrupt;
        int total;
        reset = 1'b1;
        en = 1'b0;
        cfg_base_addr = BASE;
        cfg_capacity = CAPACITY;
        fill_memory();
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        @(negedge clk);
        check_hex("valid", 0, valid, 2);
        check_hex("arvalid", 0, arvalid, 2);
        check_hex("awvalid", 0, awvalid, 2);
        check_hex("wvalid", 0, wvalid, 2);
        check_hex("bready", 0, bready, 2);
        check_hex("fault", 0, fault, 2);
        check_hex("status_idle", 1, status_idle, 2);

        @(posedge clk);
        #10;
        en = 1'b1;
        produce_limit = PAUSE_COUNT;
        while (accepted < PAUSE_COUNT) @(posedge clk);
        #10;
        en = 1'b0;

        // Drained and disabled, the receiver has to stay off the bus
        @(negedge clk);
        while (!status_idle) @(negedge clk);
        @(posedge clk);
        #10;
        quiet_check = 1'b1;
        produce_limit = PACKET_COUNT;
        repeat (40) @(posedge clk);
        #10;
        quiet_check = 1'b0;
        en = 1'b1;
        while (accepted < PACKET_COUNT || tail_writes < PACKET_COUNT) @(posedge clk);
        check_hex("tail word", PACKET_COUNT % CAPACITY, mem[TAIL_IDX].idx.index, 1);
        check_hex("model entries", 0, model_q.size(), 0);

        @(posedge clk);
        #10;
        fault_expected = 1'b1;
        corrupt = '0;
        corrupt.idx.index = CAPACITY;
        mem[HEAD_IDX] = corrupt;
        while (!fault) @(negedge clk);
        check_hex("fault_addr", BASE + HEAD_OFFSET, fault_addr, 2);
        check_hex("status_idle", 0, status_idle, 2);
        repeat (20) @(posedge clk);
        @(negedge clk);

        total = error_count[0] + error_count[1] + error_count[2];
        $display("errors: packet %0d, tail %0d, control %0d", error_count[0],
                 error_count[1], error_count[2]);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/sb_rx_pkg.sv
verilog/queue_fault.sv
verilog/mem_reader.sv
verilog/mem_writer.sv
verilog/sb_rx_queue.sv
verilog/sb_rx_top.sv
sim/sb_rx_properties.sv
sim/sb_rx_tb.sv
